//--- rtl/mem_pkg.sv
package mem_pkg;

	localparam int XLEN = 32;
	localparam int BUS_BYTES = 8;
	// byte offset bits inside one beat
	localparam int OFFSET_BITS = $clog2(BUS_BYTES);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [BUS_BYTES*8-1:0] bus_data_t;
	typedef logic [BUS_BYTES-1:0] bus_strb_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] mem_size_t;
	typedef logic [OFFSET_BITS-1:0] byte_off_t;

	localparam mem_size_t SIZE_BYTE = 2'd0;
	localparam mem_size_t SIZE_HALF = 2'd1;
	localparam mem_size_t SIZE_WORD = 2'd2;

	typedef enum logic [1:0] {LOAD_IDLE, LOAD_ADDR, LOAD_DATA, LOAD_ADDR2} load_state_t;

	typedef enum logic [2:0] {
		STORE_IDLE, STORE_ADDR, STORE_DATA, STORE_RESP, STORE_ADDR2
	} store_state_t;

	// access size in bytes
	function automatic logic [OFFSET_BITS:0] size_bytes(input mem_size_t size);
		logic [OFFSET_BITS:0] n;
		case (size)
			SIZE_BYTE: n = 1;
			SIZE_HALF: n = 2;
			default:   n = 4;
		endcase
		return n;
	endfunction

	// two beats once the access runs past the end of the 8-byte word
	function automatic logic needs_split(input byte_off_t offset, input mem_size_t size);
		return ({1'b0, offset} + size_bytes(size)) > BUS_BYTES;
	endfunction

endpackage

//--- rtl/stage_control.sv
module stage_control #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  in_valid,
	input  logic                  is_load,
	input  logic                  is_store,
	input  logic                  is_unsigned,
	input  mem_pkg::mem_size_t    size,
	input  mem_pkg::word_t        base,
	input  mem_pkg::word_t        offset,
	input  mem_pkg::word_t        store_data,
	input  mem_pkg::reg_idx_t     rd,
	output logic                  allowin,
	output logic                  load_start,
	output logic                  store_start,
	output mem_pkg::mem_size_t    op_size,
	output logic                  op_unsigned,
	output mem_pkg::word_t        op_data,
	output logic [ADDR_WIDTH-1:0] eff_addr,
	input  logic                  load_ready,
	input  mem_pkg::word_t        load_data,
	input  logic                  store_ready,
	output logic                  wb_wen,
	output mem_pkg::reg_idx_t     wb_addr,
	output mem_pkg::word_t        wb_data,
	output logic                  done
);

	logic              op_valid;
	logic              op_load;
	logic              op_store;
	logic              op_ready;
	logic              accept;
	mem_pkg::reg_idx_t op_rd;
	mem_pkg::word_t    addr_sum;

	assign accept = in_valid && allowin;
	// address adder
	assign addr_sum = base + offset;

	always_ff @(posedge clock) begin
		if (reset) begin
			op_valid <= 1'b0;
			op_load <= 1'b0;
			op_store <= 1'b0;
		end else begin
			if (allowin) begin
				op_valid <= in_valid;
			end
			if (accept) begin
				op_load <= is_load;
				op_store <= is_store;
			end
		end
	end

	// held operation fields
	always_ff @(posedge clock) begin
		if (accept) begin
			op_size <= size;
			op_unsigned <= is_unsigned;
			op_data <= store_data;
			op_rd <= rd;
			eff_addr <= ADDR_WIDTH'(addr_sum);
		end
	end

	assign load_start = op_valid && op_load;
	assign store_start = op_valid && op_store;

	// anything that is neither load nor store finishes at once
	assign op_ready = op_load ? load_ready : (op_store ? store_ready : 1'b1);

	assign allowin = !op_valid || op_ready;
	assign done = op_valid && op_ready;

	assign wb_wen = done && op_load;
	assign wb_addr = op_rd;
	assign wb_data = load_data;

endmodule

//--- rtl/load_unit.sv
module load_unit #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  load_start,
	input  logic [ADDR_WIDTH-1:0] eff_addr,
	input  mem_pkg::mem_size_t    op_size,
	input  logic                  op_unsigned,
	output logic                  arvalid,
	output logic [ADDR_WIDTH-1:0] araddr,
	input  logic                  arready,
	input  logic                  rvalid,
	input  mem_pkg::bus_data_t    rdata,
	output logic                  rready,
	output logic                  load_ready,
	output mem_pkg::word_t        load_data,
	output logic                  load_done
);

	localparam int BEAT_BITS = $bits(mem_pkg::bus_data_t);
	localparam int WIN_BITS = 2 * BEAT_BITS;
	localparam int XLEN = mem_pkg::XLEN;

	mem_pkg::load_state_t  state;
	mem_pkg::load_state_t  state_next;
	mem_pkg::byte_off_t    offset;
	logic                  split;
	logic                  second;
	logic                  beat_done;
	logic [ADDR_WIDTH-1:0] addr_lo;
	logic [ADDR_WIDTH-1:0] addr_hi;
	mem_pkg::bus_data_t    first_beat;
	logic [WIN_BITS-1:0]   window;
	logic [WIN_BITS-1:0]   shifted;
	mem_pkg::word_t        raw;

	assign offset = eff_addr[mem_pkg::OFFSET_BITS-1:0];
	assign split = mem_pkg::needs_split(offset, op_size);

	// aligned beat addresses
	assign addr_lo = {eff_addr[ADDR_WIDTH-1:mem_pkg::OFFSET_BITS],
		{mem_pkg::OFFSET_BITS{1'b0}}};
	assign addr_hi = addr_lo + ADDR_WIDTH'(mem_pkg::BUS_BYTES);

	always_comb begin
		state_next = state;
		case (state)
			mem_pkg::LOAD_IDLE: begin
				if (load_start) begin
					state_next = arready ? mem_pkg::LOAD_DATA : mem_pkg::LOAD_ADDR;
				end
			end
			mem_pkg::LOAD_ADDR, mem_pkg::LOAD_ADDR2: begin
				if (arready) begin
					state_next = mem_pkg::LOAD_DATA;
				end
			end
			mem_pkg::LOAD_DATA: begin
				if (rvalid) begin
					state_next = (split && !second) ? mem_pkg::LOAD_ADDR2 : mem_pkg::LOAD_IDLE;
				end
			end
			default: state_next = mem_pkg::LOAD_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mem_pkg::LOAD_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next == mem_pkg::LOAD_ADDR2) begin
				second <= 1'b1;
			end else if (load_done) begin
				second <= 1'b0;
			end
		end
	end

	// address is raised straight from idle so it follows acceptance by one cycle
	assign arvalid = (state == mem_pkg::LOAD_IDLE && load_start)
		|| state == mem_pkg::LOAD_ADDR || state == mem_pkg::LOAD_ADDR2;
	assign araddr = second ? addr_hi : addr_lo;
	assign rready = (state == mem_pkg::LOAD_DATA);

	assign beat_done = rvalid && rready;
	assign load_done = beat_done && (!split || second);
	assign load_ready = load_done;

	// low beat kept for the join
	always_ff @(posedge clock) begin
		if (beat_done && !second) begin
			first_beat <= rdata;
		end
	end

	// first beat sits below the second one in the window
	assign window = {rdata, split ? first_beat : rdata};
	assign shifted = window >> {offset, 3'b000};
	assign raw = shifted[XLEN-1:0];

	always_comb begin
		case (op_size)
			mem_pkg::SIZE_BYTE: load_data = {{(XLEN-8){!op_unsigned && raw[7]}}, raw[7:0]};
			mem_pkg::SIZE_HALF: load_data = {{(XLEN-16){!op_unsigned && raw[15]}}, raw[15:0]};
			default:            load_data = raw;
		endcase
	end

endmodule

//--- rtl/store_unit.sv
module store_unit #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  store_start,
	input  logic [ADDR_WIDTH-1:0] eff_addr,
	input  mem_pkg::mem_size_t    op_size,
	input  mem_pkg::word_t        op_data,
	output logic                  awvalid,
	output logic [ADDR_WIDTH-1:0] awaddr,
	input  logic                  awready,
	output logic                  wvalid,
	output mem_pkg::bus_data_t    wdata,
	output mem_pkg::bus_strb_t    wstrb,
	input  logic                  wready,
	input  logic                  bvalid,
	output logic                  bready,
	output logic                  store_ready,
	output logic                  store_done
);

	localparam int BEAT_BITS = $bits(mem_pkg::bus_data_t);
	localparam int WIN_BITS = 2 * BEAT_BITS;
	localparam int STRB_BITS = 2 * mem_pkg::BUS_BYTES;

	mem_pkg::store_state_t state;
	mem_pkg::store_state_t state_next;
	mem_pkg::byte_off_t    offset;
	logic                  split;
	logic                  second;
	logic [ADDR_WIDTH-1:0] addr_lo;
	logic [ADDR_WIDTH-1:0] addr_hi;
	logic [WIN_BITS-1:0]   data_win;
	logic [STRB_BITS-1:0]  size_mask;
	logic [STRB_BITS-1:0]  strb_win;

	assign offset = eff_addr[mem_pkg::OFFSET_BITS-1:0];
	assign split = mem_pkg::needs_split(offset, op_size);

	assign addr_lo = {eff_addr[ADDR_WIDTH-1:mem_pkg::OFFSET_BITS],
		{mem_pkg::OFFSET_BITS{1'b0}}};
	assign addr_hi = addr_lo + ADDR_WIDTH'(mem_pkg::BUS_BYTES);

	// 16-byte window, low half is the first beat
	assign data_win = {{(WIN_BITS-mem_pkg::XLEN){1'b0}}, op_data} << {offset, 3'b000};
	assign size_mask = (STRB_BITS'(1) << mem_pkg::size_bytes(op_size)) - STRB_BITS'(1);
	assign strb_win = size_mask << offset;

	always_comb begin
		state_next = state;
		case (state)
			mem_pkg::STORE_IDLE: begin
				if (store_start) begin
					state_next = awready ? mem_pkg::STORE_DATA : mem_pkg::STORE_ADDR;
				end
			end
			mem_pkg::STORE_ADDR, mem_pkg::STORE_ADDR2: begin
				if (awready) begin
					state_next = mem_pkg::STORE_DATA;
				end
			end
			mem_pkg::STORE_DATA: begin
				if (wready) begin
					state_next = mem_pkg::STORE_RESP;
				end
			end
			mem_pkg::STORE_RESP: begin
				if (bvalid) begin
					state_next = (split && !second) ? mem_pkg::STORE_ADDR2 : mem_pkg::STORE_IDLE;
				end
			end
			default: state_next = mem_pkg::STORE_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mem_pkg::STORE_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next == mem_pkg::STORE_ADDR2) begin
				second <= 1'b1;
			end else if (store_done) begin
				second <= 1'b0;
			end
		end
	end

	assign awvalid = (state == mem_pkg::STORE_IDLE && store_start)
		|| state == mem_pkg::STORE_ADDR || state == mem_pkg::STORE_ADDR2;
	assign awaddr = second ? addr_hi : addr_lo;

	// data only goes out once the address has been taken
	assign wvalid = (state == mem_pkg::STORE_DATA);
	assign wdata = second ? data_win[WIN_BITS-1:BEAT_BITS] : data_win[BEAT_BITS-1:0];
	assign wstrb = second ? strb_win[STRB_BITS-1:mem_pkg::BUS_BYTES]
		: strb_win[mem_pkg::BUS_BYTES-1:0];

	assign bready = (state == mem_pkg::STORE_RESP);

	// response of the last beat ends the store
	assign store_done = bvalid && bready && (!split || second);
	assign store_ready = store_done;

endmodule

//--- rtl/mem_stage.sv
module mem_stage #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	// from decode
	input  logic                  in_valid,
	input  logic                  is_load,
	input  logic                  is_store,
	input  logic                  is_unsigned,
	input  mem_pkg::mem_size_t    size,
	input  mem_pkg::word_t        base,
	input  mem_pkg::word_t        offset,
	input  mem_pkg::word_t        store_data,
	input  mem_pkg::reg_idx_t     rd,
	output logic                  allowin,
	// read channel
	output logic                  arvalid,
	output logic [ADDR_WIDTH-1:0] araddr,
	input  logic                  arready,
	input  logic                  rvalid,
	input  mem_pkg::bus_data_t    rdata,
	output logic                  rready,
	// write channel
	output logic                  awvalid,
	output logic [ADDR_WIDTH-1:0] awaddr,
	input  logic                  awready,
	output logic                  wvalid,
	output mem_pkg::bus_data_t    wdata,
	output mem_pkg::bus_strb_t    wstrb,
	input  logic                  wready,
	input  logic                  bvalid,
	output logic                  bready,
	// register file write-back
	output logic                  wb_wen,
	output mem_pkg::reg_idx_t     wb_addr,
	output mem_pkg::word_t        wb_data,
	output logic                  done,
	output logic                  load_done,
	output logic                  store_done
);

	logic                  load_start;
	logic                  store_start;
	mem_pkg::mem_size_t    op_size;
	logic                  op_unsigned;
	mem_pkg::word_t        op_data;
	logic [ADDR_WIDTH-1:0] eff_addr;
	logic                  load_ready;
	mem_pkg::word_t        load_data;
	logic                  store_ready;

	stage_control #(.ADDR_WIDTH(ADDR_WIDTH)) stage_control_i (
		.clock, .reset,
		.in_valid, .is_load, .is_store, .is_unsigned, .size, .base, .offset, .store_data, .rd,
		.allowin, .load_start, .store_start, .op_size, .op_unsigned, .op_data, .eff_addr,
		.load_ready, .load_data, .store_ready,
		.wb_wen, .wb_addr, .wb_data, .done
	);

	load_unit #(.ADDR_WIDTH(ADDR_WIDTH)) load_unit_i (
		.clock, .reset,
		.load_start, .eff_addr, .op_size, .op_unsigned,
		.arvalid, .araddr, .arready, .rvalid, .rdata, .rready,
		.load_ready, .load_data, .load_done
	);

	store_unit #(.ADDR_WIDTH(ADDR_WIDTH)) store_unit_i (
		.clock, .reset,
		.store_start, .eff_addr, .op_size, .op_data,
		.awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready, .bvalid, .bready,
		.store_ready, .store_done
	);

endmodule

//--- tests/mem_stage_checker.sv
module mem_stage_checker #(
	parameter int ADDR_WIDTH = 32
) (
	input logic                  clock,
	input logic                  reset,
	input logic                  in_valid,
	input logic                  arvalid,
	input logic [ADDR_WIDTH-1:0] araddr,
	input logic                  arready,
	input logic                  rvalid,
	input logic                  rready,
	input logic                  awvalid,
	input logic [ADDR_WIDTH-1:0] awaddr,
	input logic                  awready,
	input logic                  wvalid,
	input mem_pkg::bus_strb_t    wstrb,
	input logic                  wb_wen,
	input logic                  done,
	input logic                  allowin
);

	logic pending;
	logic violation = 1'b0;

	// an accepted operation stays pending until its done pulse
	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (in_valid && allowin) begin
			pending <= 1'b1;
		end else if (done) begin
			pending <= 1'b0;
		end
	end

	// address held until taken
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("read address dropped or changed before arready");
			violation = 1'b1;
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("write address dropped or changed before awready");
			violation = 1'b1;
		end

	w_strobes: assert property (@(posedge clock) disable iff (reset)
		wvalid |-> wstrb != '0)
		else begin
			$error("write beat with no strobe set");
			violation = 1'b1;
		end

	// write-back only on the read beat that ends the load
	wb_with_done: assert property (@(posedge clock) disable iff (reset)
		wb_wen |-> done && rvalid && rready)
		else begin
			$error("register write-back without done and read data");
			violation = 1'b1;
		end

	// stage stays closed while the held op runs
	stall_closed: assert property (@(posedge clock) disable iff (reset)
		pending && !done |-> !allowin)
		else begin
			$error("allowin high while an operation is pending");
			violation = 1'b1;
		end

endmodule

//--- tests/mem_stage_tb.sv
module mem_stage_tb;

	localparam int ADDR_WIDTH = 32;
	// 2 + 32 + 8 + 20 operations over the four data tests
	localparam int NUM_OPS = 62;
	localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic in_valid = 1'b0;
	logic is_load = 1'b0;
	logic is_store = 1'b0;
	logic is_unsigned = 1'b0;
	mem_pkg::mem_size_t size = '0;
	mem_pkg::word_t base = '0;
	mem_pkg::word_t offset = '0;
	mem_pkg::word_t store_data = '0;
	mem_pkg::reg_idx_t rd = '0;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	mem_pkg::bus_data_t rdata = '0;
	logic awready = 1'b0;
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	logic allowin, arvalid, rready, awvalid, wvalid, bready;
	logic wb_wen, done, load_done, store_done;
	logic [ADDR_WIDTH-1:0] araddr, awaddr;
	mem_pkg::bus_data_t wdata;
	mem_pkg::bus_strb_t wstrb;
	mem_pkg::reg_idx_t wb_addr;
	mem_pkg::word_t wb_data;

	integer seed = 32'hd643_1da4;
	logic [7:0] mem [0:255];
	logic [7:0] ref_mem [0:255];
	logic [ADDR_WIDTH-1:0] rd_addr, wr_addr;
	logic rd_busy = 1'b0;
	logic aw_taken = 1'b0;
	logic b_pend = 1'b0;
	int ar_wait, r_wait, aw_wait, w_wait, b_wait;
	int cycles = 0;
	// expected completions in issue order
	bit exp_load [$];
	mem_pkg::word_t exp_val [$];
	mem_pkg::reg_idx_t exp_rd [$];
	logic [ADDR_WIDTH-1:0] beat_addr [$];
	mem_pkg::bus_strb_t beat_strb [$];

	mem_stage #(.ADDR_WIDTH(ADDR_WIDTH)) mem_stage_i (.*);

	bind mem_stage mem_stage_checker #(.ADDR_WIDTH(ADDR_WIDTH)) mem_stage_checker_i (
		.clock, .reset, .in_valid, .arvalid, .araddr, .arready, .rvalid, .rready,
		.awvalid, .awaddr, .awready, .wvalid, .wstrb, .wb_wen, .done, .allowin
	);

	always #10 clock = !clock;

	function automatic int rand_delay();
		return $random(seed) & 3;
	endfunction

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got %h, expected %h", name, actual, expected);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	function automatic int size_len(input mem_pkg::mem_size_t sz);
		return (sz == mem_pkg::SIZE_BYTE) ? 1 : ((sz == mem_pkg::SIZE_HALF) ? 2 : 4);
	endfunction

	// value a load should return, built from the reference bytes
	function automatic mem_pkg::word_t expect_load(input logic [7:0] addr,
			input mem_pkg::mem_size_t sz, input logic uns);
		mem_pkg::word_t v;
		int n;
		n = size_len(sz);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[8*i +: 8] = ref_mem[8'(addr + i)];
		end
		if (!uns && v[8*n-1]) begin
			v = v | ~((32'd1 << (8*n)) - 1);
		end
		return v;
	endfunction

	// read side of the SRAM model
	always @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rd_busy <= 1'b0;
			ar_wait <= rand_delay();
		end else begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_addr <= araddr;
				rd_busy <= 1'b1;
				r_wait <= rand_delay();
			end else if (arvalid && !rd_busy) begin
				if (ar_wait == 0) begin
					arready <= 1'b1;
					ar_wait <= rand_delay();
				end else begin
					ar_wait <= ar_wait - 1;
				end
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				rd_busy <= 1'b0;
			end else if (rd_busy && !rvalid) begin
				if (r_wait == 0) begin
					rvalid <= 1'b1;
					for (int k = 0; k < 8; k++) begin
						rdata[8*k +: 8] <= mem[8'(rd_addr + k)];
					end
				end else begin
					r_wait <= r_wait - 1;
				end
			end
		end
	end

	// write side of the SRAM model
	always @(posedge clock) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			aw_taken <= 1'b0;
			b_pend <= 1'b0;
			aw_wait <= rand_delay();
		end else begin
			if (awvalid && awready) begin
				awready <= 1'b0;
				wr_addr <= awaddr;
				aw_taken <= 1'b1;
				w_wait <= rand_delay();
			end else if (awvalid && !aw_taken) begin
				if (aw_wait == 0) begin
					awready <= 1'b1;
					aw_wait <= rand_delay();
				end else begin
					aw_wait <= aw_wait - 1;
				end
			end
			if (wvalid && wready) begin
				wready <= 1'b0;
				for (int k = 0; k < 8; k++) begin
					if (wstrb[k]) begin
						mem[8'(wr_addr + k)] <= wdata[8*k +: 8];
					end
				end
				beat_addr.push_back(wr_addr);
				beat_strb.push_back(wstrb);
				b_pend <= 1'b1;
				b_wait <= rand_delay();
			end else if (wvalid && !wready && !b_pend) begin
				if (w_wait == 0) begin
					wready <= 1'b1;
				end else begin
					w_wait <= w_wait - 1;
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				b_pend <= 1'b0;
				aw_taken <= 1'b0;
			end else if (b_pend && !bvalid) begin
				if (b_wait == 0) begin
					bvalid <= 1'b1;
				end else begin
					b_wait <= b_wait - 1;
				end
			end
		end
	end

	// completion monitor, sampled away from the clock edge
	always @(negedge clock) begin
		if (!reset && done) begin
			if (exp_load.size() == 0) begin
				$display("done pulsed with no operation outstanding");
				$display("Simulation FAILED");
				$fatal(1);
			end
			check("wb_wen", wb_wen, exp_load[0]);
			check("load_done", load_done, exp_load[0]);
			check("store_done", store_done, !exp_load[0]);
			if (exp_load[0]) begin
				check("wb_addr", wb_addr, exp_rd[0]);
				check("wb_data", wb_data, exp_val[0]);
			end
			void'(exp_load.pop_front());
			void'(exp_val.pop_front());
			void'(exp_rd.pop_front());
		end else if (!reset) begin
			check("load_done", load_done, 0);
			check("store_done", store_done, 0);
		end
	end

	always @(negedge clock) begin
		if (mem_stage_i.mem_stage_checker_i.violation) begin
			$display("a protocol assertion in the bound checker failed");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("run took too long, an operation never finished");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	// hold the op on the inputs until the stage takes it
	task automatic send_op(input logic ld, input logic uns, input mem_pkg::mem_size_t sz,
			input mem_pkg::word_t addr, input mem_pkg::word_t data,
			input mem_pkg::reg_idx_t r);
		mem_pkg::word_t split_off;
		split_off = 32'($random(seed) & 15);
		exp_load.push_back(ld);
		exp_rd.push_back(r);
		exp_val.push_back(ld ? expect_load(addr[7:0], sz, uns) : '0);
		if (!ld) begin
			for (int i = 0; i < size_len(sz); i++) begin
				ref_mem[8'(addr + i)] = data[8*i +: 8];
			end
		end
		@(posedge clock);
		in_valid <= 1'b1;
		is_load <= ld;
		is_store <= !ld;
		is_unsigned <= uns;
		size <= sz;
		base <= addr - split_off;
		offset <= split_off;
		store_data <= data;
		rd <= r;
		do begin
			@(negedge clock);
		end while (!allowin);
		@(posedge clock);
		in_valid <= 1'b0;
	endtask

	task automatic drain();
		while (exp_load.size() != 0) begin
			@(negedge clock);
		end
	endtask

	task automatic test_reset_state();
		@(negedge clock);
		check("allowin", allowin, 1);
		check("arvalid", arvalid, 0);
		check("rready", rready, 0);
		check("awvalid", awvalid, 0);
		check("wvalid", wvalid, 0);
		check("bready", bready, 0);
		check("wb_wen", wb_wen, 0);
		check("done", done, 0);
		check("load_done", load_done, 0);
		check("store_done", store_done, 0);
	endtask

	task automatic test_word_roundtrip();
		send_op(0, 0, mem_pkg::SIZE_WORD, 32'h10, 32'hcafe_f00d, 5'd0);
		send_op(1, 0, mem_pkg::SIZE_WORD, 32'h10, '0, 5'd9);
		drain();
	endtask

	task automatic test_narrow_loads();
		for (int off = 0; off < 8; off++) begin
			for (int u = 0; u < 2; u++) begin
				send_op(1, u[0], mem_pkg::SIZE_BYTE, 32'(64 + off), '0, 5'(off + 1));
				send_op(1, u[0], mem_pkg::SIZE_HALF, 32'(64 + off), '0, 5'(off + 11));
			end
		end
		drain();
	endtask

	task automatic test_split_stores();
		int offs [4] = '{5, 6, 7, 7};
		mem_pkg::mem_size_t sizes [4];
		logic [15:0] win;
		logic [ADDR_WIDTH-1:0] aligned;
		sizes = '{mem_pkg::SIZE_WORD, mem_pkg::SIZE_WORD, mem_pkg::SIZE_WORD,
			mem_pkg::SIZE_HALF};
		for (int k = 0; k < 4; k++) begin
			aligned = ADDR_WIDTH'(96 + 16 * k);
			// bytes the store covers across both beats
			win = '0;
			for (int i = 0; i < size_len(sizes[k]); i++) begin
				win[offs[k] + i] = 1'b1;
			end
			beat_addr.delete();
			beat_strb.delete();
			send_op(0, 0, sizes[k], aligned + offs[k], 32'h8a3c_51e7 + k, 5'd0);
			drain();
			check("write beats", beat_addr.size(), 2);
			check("awaddr beat 1", beat_addr[0], aligned);
			check("awaddr beat 2", beat_addr[1], aligned + 8);
			check("wstrb beat 1", beat_strb[0], win[7:0]);
			check("wstrb beat 2", beat_strb[1], win[15:8]);
			send_op(1, 1, sizes[k], aligned + offs[k], '0, 5'(20 + k));
			drain();
		end
	endtask

	task automatic test_random_traffic();
		logic ld;
		mem_pkg::mem_size_t sz;
		for (int n = 0; n < 20; n++) begin
			ld = $random(seed) & 1;
			sz = mem_pkg::mem_size_t'($unsigned($random(seed)) % 3);
			send_op(ld, $random(seed) & 1, sz, 32'(128 + ($random(seed) & 63)),
				$random(seed), 5'($random(seed)));
		end
		drain();
	endtask

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i * 37 + (i >> 3) + 8'h5b);
			ref_mem[i] = mem[i];
		end
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		test_reset_state();
		test_word_roundtrip();
		test_narrow_loads();
		test_split_stores();
		test_random_traffic();
		repeat (2) @(negedge clock);
		for (int i = 0; i < 256; i++) begin
			check("sram byte", mem[i], ref_mem[i]);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- mem_stage.f
rtl/mem_pkg.sv
rtl/stage_control.sv
rtl/load_unit.sv
rtl/store_unit.sv
rtl/mem_stage.sv
tests/mem_stage_checker.sv
tests/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - rtl/mem_pkg.sv
  - rtl/stage_control.sv
  - rtl/load_unit.sv
  - rtl/store_unit.sv
  - rtl/mem_stage.sv
  - target: test
    files:
      - tests/mem_stage_checker.sv
      - tests/mem_stage_tb.sv
